/* common/svc_defines.svh */
// Command codes are single bytes; a code not listed here is ignored by the decoder

`ifndef SVC_DEFINES_SVH
`define SVC_DEFINES_SVH

// ------------------------------
// Command codes
// ------------------------------
`define SVC_CMD_CORE_AWUSER   8'h01
`define SVC_CMD_MCU_AWUSER    8'h02
`define SVC_CMD_REL_AWUSER    8'h03
`define SVC_CMD_ZEROIZE       8'h04
`define SVC_CMD_ZEROIZE_RST   8'h05
`define SVC_CMD_REL_ZEROIZE   8'h06
`define SVC_CMD_FAULT_DIGEST  8'h07
`define SVC_CMD_FAULT_BUS_ECC 8'h08
`define SVC_CMD_FC_ESC        8'h09
`define SVC_CMD_LC_ESC0       8'h0A
`define SVC_CMD_LC_ESC1       8'h0B
`define SVC_CMD_CLK_500       8'h0C
`define SVC_CMD_CLK_160       8'h0D
`define SVC_CMD_CLK_400       8'h0E
`define SVC_CMD_CLK_1000      8'h0F
`define SVC_CMD_SUB_RESET     8'h10
`define SVC_CMD_RMA_PPD       8'h11

// ------------------------------
// Override lanes
// ------------------------------
`define SVC_LANE_AWUSER   0
`define SVC_LANE_ROM_MASK 1
`define SVC_LANE_DIGEST   2
`define SVC_NUM_LANES     3

// Last counter value of the stretched reset, which gives 11 low cycles
`define SVC_RST_HOLD_CYCLES 10

// Writes to this fuse address get bit 0 of the data flipped when armed
`define SVC_FAULT_ADDR 32'h7000_0068

`endif

/* common/svc_pkg.sv */
// Types only; F500 must stay at encoding zero because reset clears the whole status word

package svc_pkg;

  // ------------------------------
  // Command and lane control
  // ------------------------------
  typedef logic [7:0] svc_cmd_t;

  typedef enum logic [1:0] {
    NONE  = 2'd0,
    SET   = 2'd1,
    CLEAR = 2'd2
  } svc_lane_op_e;

  // Request and override of a 32-bit word lane
  typedef struct packed {
    svc_lane_op_e op;
    logic [31:0]  value;
  } svc_word_req_t;

  typedef struct packed {
    logic        active;
    logic [31:0] value;
  } svc_word_ovr_t;

  // Zeroization flags share the lane shape with a 2-bit payload
  typedef struct packed {
    logic ppd;
    logic scrap;
  } svc_zero_flags_t;

  typedef struct packed {
    svc_lane_op_e    op;
    svc_zero_flags_t value;
  } svc_zero_req_t;

  typedef struct packed {
    logic            active;
    svc_zero_flags_t value;
  } svc_zero_ovr_t;

  // ------------------------------
  // Status and observed bundle
  // ------------------------------
  typedef enum logic [1:0] {
    F500  = 2'd0,
    F160  = 2'd1,
    F400  = 2'd2,
    F1000 = 2'd3
  } svc_freq_e;

  typedef struct packed {
    svc_freq_e freq_sel;
    logic      fc_esc;
    logic      lc_esc0;
    logic      lc_esc1;
    logic      allow_rma_ppd;
    logic      fault_arm;
  } svc_status_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] user;
  } svc_wr_req_t;

  // Used both for the observed signals and for their overridden copy
  typedef struct packed {
    svc_wr_req_t wr_req;
    logic [1:0]  bresp;
    logic [31:0] rom_mask;
    logic [31:0] digest;
    logic        ppd;
    logic        scrap;
  } svc_obs_t;

endpackage

/* override/svc_override_lane.sv */
// req_t needs op and value fields, ovr_t needs active and value fields of the same payload type

module svc_override_lane #(
  parameter type req_t = svc_pkg::svc_word_req_t,
  parameter type ovr_t = svc_pkg::svc_word_ovr_t
) (
  input  logic clk,
  input  logic cptra_rst_b,
  input  req_t req_i,
  output ovr_t ovr_o
);

  ovr_t ovr_q;

  // SET and CLEAR come from different codes so they never meet in one cycle
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ovr_q <= '0;
    end else begin
      case (req_i.op)
        svc_pkg::SET: begin
          ovr_q.active <= 1'b1;
          ovr_q.value  <= req_i.value;
        end
        svc_pkg::CLEAR: begin
          ovr_q.active <= 1'b0;
          ovr_q.value  <= '0;
        end
        default: begin
          // Hold the current override
        end
      endcase
    end
  end

  assign ovr_o = ovr_q;

endmodule

/* override/svc_override_apply.sv */
// Purely combinational; bresp reads zero only for armed writes to the fault address

`include "svc_defines.svh"

module svc_override_apply (
  input  svc_pkg::svc_word_ovr_t [`SVC_NUM_LANES-1:0] lane_ovr_i,
  input  svc_pkg::svc_zero_ovr_t                      zero_ovr_i,
  input  logic                                        fault_arm_i,
  input  svc_pkg::svc_obs_t                           obs_i,
  output svc_pkg::svc_obs_t                           obs_o
);

  logic fault_hit;

  // Only the monitored fuse address gets the bit flip
  assign fault_hit = fault_arm_i && (obs_i.wr_req.addr == `SVC_FAULT_ADDR);

  always_comb begin
    obs_o = obs_i;

    // ------------------------------
    // Field overrides
    // ------------------------------
    if (lane_ovr_i[`SVC_LANE_AWUSER].active) begin
      obs_o.wr_req.user = lane_ovr_i[`SVC_LANE_AWUSER].value;
    end
    if (lane_ovr_i[`SVC_LANE_ROM_MASK].active) begin
      obs_o.rom_mask = lane_ovr_i[`SVC_LANE_ROM_MASK].value;
    end
    if (lane_ovr_i[`SVC_LANE_DIGEST].active) begin
      obs_o.digest = lane_ovr_i[`SVC_LANE_DIGEST].value;
    end
    if (zero_ovr_i.active) begin
      obs_o.ppd   = zero_ovr_i.value.ppd;
      obs_o.scrap = zero_ovr_i.value.scrap;
    end

    // ------------------------------
    // Bus fault injection
    // ------------------------------
    if (fault_hit) begin
      obs_o.wr_req.data[0] = ~obs_i.wr_req.data[0];
      // The corrupted write still reports an OKAY response
      obs_o.bresp          = 2'b00;
    end
  end

endmodule

/* verilog/svc_cmd_decoder.sv */
// Lane requests are combinational and only valid in the cycle of the command strobe; no back-pressure

`include "svc_defines.svh"

module svc_cmd_decoder (
  input  logic                                        clk,
  input  logic                                        cptra_rst_b,
  input  logic                                        cmd_valid_i,
  input  svc_pkg::svc_cmd_t                           cmd_i,
  input  logic [31:0]                                 core_user_i,
  input  logic [31:0]                                 mcu_user_i,
  output svc_pkg::svc_word_req_t [`SVC_NUM_LANES-1:0] lane_req_o,
  output svc_pkg::svc_zero_req_t                      zero_req_o,
  output svc_pkg::svc_status_t                        status_o,
  output logic                                        rst_start_o
);

  svc_pkg::svc_status_t status_q;

  // ------------------------------
  // Lane requests
  // ------------------------------
  always_comb begin
    lane_req_o = '0;
    zero_req_o = '0;
    if (cmd_valid_i) begin
      case (cmd_i)
        `SVC_CMD_CORE_AWUSER: begin
          lane_req_o[`SVC_LANE_AWUSER].op    = svc_pkg::SET;
          lane_req_o[`SVC_LANE_AWUSER].value = core_user_i;
        end
        `SVC_CMD_MCU_AWUSER: begin
          lane_req_o[`SVC_LANE_AWUSER].op    = svc_pkg::SET;
          lane_req_o[`SVC_LANE_AWUSER].value = mcu_user_i;
        end
        `SVC_CMD_REL_AWUSER: begin
          lane_req_o[`SVC_LANE_AWUSER].op = svc_pkg::CLEAR;
        end
        `SVC_CMD_ZEROIZE: begin
          lane_req_o[`SVC_LANE_ROM_MASK].op    = svc_pkg::SET;
          lane_req_o[`SVC_LANE_ROM_MASK].value = 32'hFFFF_FFFF;
          zero_req_o.op          = svc_pkg::SET;
          zero_req_o.value.ppd   = 1'b1;
          zero_req_o.value.scrap = 1'b0;
        end
        `SVC_CMD_ZEROIZE_RST: begin
          // Mask stays active but forced to zero, device reported as scrapped
          lane_req_o[`SVC_LANE_ROM_MASK].op    = svc_pkg::SET;
          lane_req_o[`SVC_LANE_ROM_MASK].value = 32'h0;
          zero_req_o.op          = svc_pkg::SET;
          zero_req_o.value.ppd   = 1'b0;
          zero_req_o.value.scrap = 1'b1;
        end
        `SVC_CMD_REL_ZEROIZE: begin
          lane_req_o[`SVC_LANE_ROM_MASK].op = svc_pkg::CLEAR;
          zero_req_o.op                     = svc_pkg::CLEAR;
        end
        `SVC_CMD_FAULT_DIGEST: begin
          lane_req_o[`SVC_LANE_DIGEST].op    = svc_pkg::SET;
          lane_req_o[`SVC_LANE_DIGEST].value = 32'h0;
        end
        default: begin
          // Status, reset and unknown codes issue no lane request
        end
      endcase
    end
  end

  // ------------------------------
  // Sticky status
  // ------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      status_q.freq_sel      <= svc_pkg::F500;
      status_q.fc_esc        <= 1'b0;
      status_q.lc_esc0       <= 1'b0;
      status_q.lc_esc1       <= 1'b0;
      status_q.allow_rma_ppd <= 1'b0;
      status_q.fault_arm     <= 1'b0;
    end else if (cmd_valid_i) begin
      case (cmd_i)
        `SVC_CMD_FAULT_BUS_ECC: status_q.fault_arm     <= 1'b1;
        `SVC_CMD_FC_ESC:        status_q.fc_esc        <= 1'b1;
        `SVC_CMD_LC_ESC0:       status_q.lc_esc0       <= 1'b1;
        `SVC_CMD_LC_ESC1:       status_q.lc_esc1       <= 1'b1;
        `SVC_CMD_RMA_PPD:       status_q.allow_rma_ppd <= 1'b1;
        `SVC_CMD_CLK_500:       status_q.freq_sel      <= svc_pkg::F500;
        `SVC_CMD_CLK_160:       status_q.freq_sel      <= svc_pkg::F160;
        `SVC_CMD_CLK_400:       status_q.freq_sel      <= svc_pkg::F400;
        `SVC_CMD_CLK_1000:      status_q.freq_sel      <= svc_pkg::F1000;
        default: begin
        end
      endcase
    end
  end

  assign status_o = status_q;

  // Single-cycle start pulse, the stretcher drops it while a reset is running
  assign rst_start_o = cmd_valid_i && (cmd_i == `SVC_CMD_SUB_RESET);

endmodule

/* verilog/svc_reset_stretcher.sv */
// Output is low for SVC_RST_HOLD_CYCLES+1 cycles from the start edge; starts during a hold are dropped

`include "svc_defines.svh"

module svc_reset_stretcher (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic start_i,
  output logic sub_rst_b_o
);

  logic       active_q;
  logic [3:0] cnt_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      active_q <= 1'b0;
      cnt_q    <= 4'd0;
    end else if (!active_q) begin
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= 4'd0;
      end
    end else if (cnt_q == 4'(`SVC_RST_HOLD_CYCLES)) begin
      // Last low cycle, release on this edge
      active_q <= 1'b0;
      cnt_q    <= 4'd0;
    end else begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  assign sub_rst_b_o = ~active_q;

endmodule

/* verilog/svc_top.sv */
// Overrides show on obs_o one cycle after the command edge; obs_o is combinational from obs_i

`include "svc_defines.svh"

module svc_top (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  logic                 cmd_valid_i,
  input  svc_pkg::svc_cmd_t    cmd_i,
  input  logic [31:0]          core_user_i,
  input  logic [31:0]          mcu_user_i,
  input  svc_pkg::svc_obs_t    obs_i,
  output svc_pkg::svc_obs_t    obs_o,
  output svc_pkg::svc_status_t status_o,
  output logic                 sub_rst_b_o
);

  svc_pkg::svc_word_req_t [`SVC_NUM_LANES-1:0] lane_req;
  svc_pkg::svc_word_ovr_t [`SVC_NUM_LANES-1:0] lane_ovr;
  svc_pkg::svc_zero_req_t                      zero_req;
  svc_pkg::svc_zero_ovr_t                      zero_ovr;
  svc_pkg::svc_status_t                        status;
  logic                                        rst_start;

  // ------------------------------
  // Command decode
  // ------------------------------
  svc_cmd_decoder u_decoder (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .core_user_i (core_user_i),
    .mcu_user_i  (mcu_user_i),
    .lane_req_o  (lane_req),
    .zero_req_o  (zero_req),
    .status_o    (status),
    .rst_start_o (rst_start)
  );

  // ------------------------------
  // Override lanes
  // ------------------------------
  for (genvar i = 0; i < `SVC_NUM_LANES; i++) begin : g_word_lane
    svc_override_lane #(
      .req_t (svc_pkg::svc_word_req_t),
      .ovr_t (svc_pkg::svc_word_ovr_t)
    ) u_lane (
      .clk         (clk),
      .cptra_rst_b (cptra_rst_b),
      .req_i       (lane_req[i]),
      .ovr_o       (lane_ovr[i])
    );
  end

  // Same lane, carrying the ppd and scrap flags
  svc_override_lane #(
    .req_t (svc_pkg::svc_zero_req_t),
    .ovr_t (svc_pkg::svc_zero_ovr_t)
  ) u_zero_lane (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .req_i       (zero_req),
    .ovr_o       (zero_ovr)
  );

  svc_override_apply u_apply (
    .lane_ovr_i  (lane_ovr),
    .zero_ovr_i  (zero_ovr),
    .fault_arm_i (status.fault_arm),
    .obs_i       (obs_i),
    .obs_o       (obs_o)
  );

  svc_reset_stretcher u_rst_stretch (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .start_i     (rst_start),
    .sub_rst_b_o (sub_rst_b_o)
  );

  assign status_o = status;

endmodule

/* tb/svc_tb.sv */
// Outputs are sampled on the falling edge; a cycle limit ends a run that hangs
`include "svc_defines.svh"

module svc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STIM_CYCLES    = 116;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
  localparam svc_pkg::svc_cmd_t STATUS_CMDS [10] = '{
    `SVC_CMD_FC_ESC, `SVC_CMD_LC_ESC0, `SVC_CMD_LC_ESC1, `SVC_CMD_RMA_PPD,
    `SVC_CMD_CLK_160, `SVC_CMD_CLK_400, `SVC_CMD_CLK_1000, `SVC_CMD_CLK_500,
    8'h3C, 8'hFF
  };

  logic                 clk = 1'b0;
  logic                 cptra_rst_b;
  logic                 cmd_valid_i;
  svc_pkg::svc_cmd_t    cmd_i;
  logic [31:0]          core_user_i;
  logic [31:0]          mcu_user_i;
  svc_pkg::svc_obs_t    obs_i;
  svc_pkg::svc_obs_t    obs_o;
  svc_pkg::svc_status_t status_o;
  logic                 sub_rst_b_o;

  integer seed = 32'h88b4_2954;
  int     cycle_cnt = 0;
  int     checks = 0;
  int     obs_errors = 0;
  int     status_errors = 0;
  int     rst_errors = 0;

  // Reference model of the lanes, the status register and the reset window
  svc_pkg::svc_word_ovr_t [`SVC_NUM_LANES-1:0] mdl_lane = '0;
  svc_pkg::svc_zero_ovr_t                      mdl_zero = '0;
  svc_pkg::svc_status_t                        mdl_status = '0;
  int                                          mdl_rst_cnt = 0;

  svc_top UUT (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .core_user_i (core_user_i),
    .mcu_user_i  (mcu_user_i),
    .obs_i       (obs_i),
    .obs_o       (obs_o),
    .status_o    (status_o),
    .sub_rst_b_o (sub_rst_b_o)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic model_command(input svc_pkg::svc_cmd_t cmd);
    case (cmd)
      `SVC_CMD_CORE_AWUSER: mdl_lane[`SVC_LANE_AWUSER] = {1'b1, core_user_i};
      `SVC_CMD_MCU_AWUSER:  mdl_lane[`SVC_LANE_AWUSER] = {1'b1, mcu_user_i};
      `SVC_CMD_REL_AWUSER:  mdl_lane[`SVC_LANE_AWUSER] = '0;
      `SVC_CMD_ZEROIZE: begin
        mdl_lane[`SVC_LANE_ROM_MASK] = {1'b1, 32'hFFFF_FFFF};
        mdl_zero = {1'b1, 1'b1, 1'b0};
      end
      `SVC_CMD_ZEROIZE_RST: begin
        mdl_lane[`SVC_LANE_ROM_MASK] = {1'b1, 32'h0};
        mdl_zero = {1'b1, 1'b0, 1'b1};
      end
      `SVC_CMD_REL_ZEROIZE: begin
        mdl_lane[`SVC_LANE_ROM_MASK] = '0;
        mdl_zero = '0;
      end
      `SVC_CMD_FAULT_DIGEST:  mdl_lane[`SVC_LANE_DIGEST] = {1'b1, 32'h0};
      `SVC_CMD_FAULT_BUS_ECC: mdl_status.fault_arm = 1'b1;
      `SVC_CMD_FC_ESC:        mdl_status.fc_esc = 1'b1;
      `SVC_CMD_LC_ESC0:       mdl_status.lc_esc0 = 1'b1;
      `SVC_CMD_LC_ESC1:       mdl_status.lc_esc1 = 1'b1;
      `SVC_CMD_RMA_PPD:       mdl_status.allow_rma_ppd = 1'b1;
      `SVC_CMD_CLK_500:       mdl_status.freq_sel = svc_pkg::F500;
      `SVC_CMD_CLK_160:       mdl_status.freq_sel = svc_pkg::F160;
      `SVC_CMD_CLK_400:       mdl_status.freq_sel = svc_pkg::F400;
      `SVC_CMD_CLK_1000:      mdl_status.freq_sel = svc_pkg::F1000;
      default: begin
      end
    endcase
  endtask

  always @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      mdl_lane = '0;
      mdl_zero = '0;
      mdl_status = '0;
      mdl_rst_cnt = 0;
    end else begin
      // A running window only counts down, so a new reset command is dropped
      if (mdl_rst_cnt != 0) begin
        mdl_rst_cnt = mdl_rst_cnt - 1;
      end else if (cmd_valid_i && cmd_i == `SVC_CMD_SUB_RESET) begin
        mdl_rst_cnt = `SVC_RST_HOLD_CYCLES + 1;
      end
      if (cmd_valid_i) begin
        model_command(cmd_i);
      end
    end
  end

  function automatic svc_pkg::svc_obs_t expected_obs(input svc_pkg::svc_obs_t in);
    svc_pkg::svc_obs_t exp;
    exp = in;
    if (mdl_lane[`SVC_LANE_AWUSER].active) exp.wr_req.user = mdl_lane[`SVC_LANE_AWUSER].value;
    if (mdl_lane[`SVC_LANE_ROM_MASK].active) exp.rom_mask = mdl_lane[`SVC_LANE_ROM_MASK].value;
    if (mdl_lane[`SVC_LANE_DIGEST].active) exp.digest = mdl_lane[`SVC_LANE_DIGEST].value;
    if (mdl_zero.active) begin
      exp.ppd   = mdl_zero.value.ppd;
      exp.scrap = mdl_zero.value.scrap;
    end
    // Only writes to the fault address are corrupted, other addresses pass unchanged
    if (mdl_status.fault_arm && in.wr_req.addr == `SVC_FAULT_ADDR) begin
      exp.wr_req.data = in.wr_req.data ^ 32'h1;
      exp.bresp       = 2'b00;
    end
    return exp;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_obs(input svc_pkg::svc_obs_t got, input svc_pkg::svc_obs_t exp);
    checks++;
    if (got !== exp) begin
      obs_errors++;
      $display("Error at %0t ns: obs_o is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_status(input svc_pkg::svc_status_t got,
                                input svc_pkg::svc_status_t exp);
    checks++;
    if (got !== exp) begin
      status_errors++;
      $display("Error at %0t ns: status_o is %h, expected %h", $time, got, exp);
    end
  endtask

  always @(negedge clk) begin
    compare_obs(obs_o, expected_obs(obs_i));
    compare_status(status_o, mdl_status);
    checks++;
    if (sub_rst_b_o !== (mdl_rst_cnt == 0)) begin
      rst_errors++;
      $display("Error at %0t ns: sub_rst_b_o is %b, expected %b",
               $time, sub_rst_b_o, (mdl_rst_cnt == 0));
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic drive_random_inputs();
    svc_pkg::svc_obs_t obs;
    logic [31:0]       r;
    r = $random(seed);
    // Half of the writes go to the fault address
    obs.wr_req.addr = r[0] ? `SVC_FAULT_ADDR : $random(seed);
    obs.wr_req.data = $random(seed);
    obs.wr_req.user = $random(seed);
    obs.bresp       = r[2:1];
    obs.rom_mask    = $random(seed);
    obs.digest      = $random(seed);
    obs.ppd         = r[3];
    obs.scrap       = r[4];
    obs_i       <= obs;
    core_user_i <= $random(seed);
    mcu_user_i  <= $random(seed);
  endtask

  task automatic send_cmd(input svc_pkg::svc_cmd_t cmd);
    @(posedge clk);
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    drive_random_inputs();
  endtask

  // Random codes without the strobe must not be taken
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_valid_i <= 1'b0;
      cmd_i       <= 8'($random(seed));
      drive_random_inputs();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    cptra_rst_b = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    core_user_i = '0;
    mcu_user_i  = '0;
    obs_i       = '0;
    repeat (3) @(posedge clk);
    cptra_rst_b <= 1'b1;
    idle(8);

    send_cmd(`SVC_CMD_CORE_AWUSER);
    idle(3);
    send_cmd(`SVC_CMD_MCU_AWUSER);
    idle(3);
    send_cmd(`SVC_CMD_REL_AWUSER);
    idle(3);

    send_cmd(`SVC_CMD_ZEROIZE);
    idle(3);
    send_cmd(`SVC_CMD_ZEROIZE_RST);
    idle(3);
    send_cmd(`SVC_CMD_REL_ZEROIZE);
    idle(3);

    send_cmd(`SVC_CMD_FAULT_BUS_ECC);
    idle(8);
    send_cmd(`SVC_CMD_FAULT_DIGEST);
    idle(3);

    for (int i = 0; i < 10; i++) begin
      send_cmd(STATUS_CMDS[i]);
      idle(2);
    end

    // Second reset command lands inside the first window
    send_cmd(`SVC_CMD_SUB_RESET);
    idle(4);
    send_cmd(`SVC_CMD_SUB_RESET);
    idle(14);
    send_cmd(`SVC_CMD_SUB_RESET);
    idle(14);
    idle(2);
    @(posedge clk);

    $display("Checks %0d, errors %0d (obs_o %0d, status_o %0d, sub_rst_b_o %0d)",
             checks, obs_errors + status_errors + rst_errors,
             obs_errors, status_errors, rst_errors);
    if (obs_errors + status_errors + rst_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/svc_pkg.sv
override/svc_override_lane.sv
override/svc_override_apply.sv
verilog/svc_cmd_decoder.sv
verilog/svc_reset_stretcher.sv
verilog/svc_top.sv
tb/svc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles and runs the svc testbench with Verilator; exits non-zero on failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module svc_tb -Mdir obj_dir -o svc_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/svc_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
